// ==== verilog/grid_consts.svh ====
`ifndef GRID_CONSTS_SVH
`define GRID_CONSTS_SVH

// grid shape
`define GRID_STEPS       8  // columns, one per sequencer step
`define GRID_INSTRUMENTS 4  // rows, one per instrument

// square shape in pixels
`define SQUARE_SIDE      4
`define SQUARE_PIXELS    16 // side squared

// screen placement
`define GRID_X0          10 // left edge of column 0
`define GRID_Y0          20 // top edge of row 0
`define GRID_PITCH       20 // distance between square origins

// colour codes, red green blue
`define COLOUR_HIT       3'b100 // note playing now
`define COLOUR_NOTE      3'b010 // note set, other step
`define COLOUR_CURSOR    3'b001 // current step, no note
`define COLOUR_EMPTY     3'b111 // nothing

`endif

// ==== verilog/grid_pkg.sv ====
package grid_pkg;

	// position of one square on the grid
	typedef struct packed {
		logic [2:0] step;       // column
		logic [1:0] instrument; // row
	} square_pos_t;

	// squares are numbered column by column, so the flat
	// number and the column/row split are the same five bits
	typedef union packed {
		logic [4:0]  num; // 0 to 31
		square_pos_t pos;
	} square_index_u;

	// pixel inside a square, [1:0] is x and [3:2] is y
	typedef logic [3:0] pixel_offset_t;

	// one instrument, note on or off per step
	typedef logic [7:0] step_pattern_t;

	// current step 1 to 8, 0 lights no column
	typedef logic [3:0] step_timing_t;

endpackage

// ==== verilog/pixel_pkg.sv ====
package pixel_pkg;

	// screen address of one pixel
	typedef logic [7:0] x_coord_t; // 0 to 159 on a 160 wide screen
	typedef logic [6:0] y_coord_t; // 0 to 119

	// one bit per channel: red, green, blue
	typedef logic [2:0] colour_t;

endpackage

// ==== verilog/square_scanner.sv ====
`timescale 1ns/1ps
`include "grid_consts.svh"

module square_scanner (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    play,
	output grid_pkg::square_index_u square,
	output grid_pkg::pixel_offset_t offset
);

	// offset counts down from the last pixel of a square
	localparam grid_pkg::pixel_offset_t offset_first =
		grid_pkg::pixel_offset_t'(`SQUARE_PIXELS - 1);

	logic offset_done; // last pixel of the current square
	logic [4:0] square_inc;

	assign offset_done = (offset == '0);
	assign square_inc = square.num + 5'd1; // 31 wraps to 0

	// pixel counter
	always_ff @(posedge clk) begin
		if (!reset) begin
			offset <= offset_first;
		end else if (play) begin
			if (offset_done) begin
				offset <= offset_first; // next square starts over
			end else begin
				offset <= offset - 4'd1;
			end
		end
	end

	// square counter, steps once per 16 pixels
	always_ff @(posedge clk) begin
		if (!reset) begin
			square.num <= '0;
		end else if (play && offset_done) begin
			square.num <= square_inc;
		end
	end

endmodule

// ==== verilog/cell_shader.sv ====
`timescale 1ns/1ps
`include "grid_consts.svh"

module cell_shader (
	input  grid_pkg::square_index_u square,
	input  grid_pkg::step_pattern_t ins1,
	input  grid_pkg::step_pattern_t ins2,
	input  grid_pkg::step_pattern_t ins3,
	input  grid_pkg::step_pattern_t ins4,
	input  grid_pkg::step_timing_t  timing,
	output pixel_pkg::colour_t      colour_next
);

	grid_pkg::step_pattern_t patterns [`GRID_INSTRUMENTS]; // one per row
	logic [`GRID_STEPS-1:0]  row_pattern;
	grid_pkg::step_timing_t  step_number; // column counted from 1
	logic                    active;
	logic                    current;

	always_comb begin
		patterns[0] = ins1;
		patterns[1] = ins2;
		patterns[2] = ins3;
		patterns[3] = ins4;
	end

	assign row_pattern = patterns[square.pos.instrument];
	assign active = row_pattern[square.pos.step]; // note set in this cell

	// timing 0 never matches, so no column lights
	assign step_number = grid_pkg::step_timing_t'(square.pos.step) + 4'd1;
	assign current = (timing == step_number);

	always_comb begin
		case ({active, current})
			2'b11:   colour_next = `COLOUR_HIT;
			2'b10:   colour_next = `COLOUR_NOTE;
			2'b01:   colour_next = `COLOUR_CURSOR;
			default: colour_next = `COLOUR_EMPTY;
		endcase
	end

endmodule

// ==== verilog/pixel_emitter.sv ====
`timescale 1ns/1ps
`include "grid_consts.svh"

module pixel_emitter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    play,
	input  grid_pkg::square_index_u square,
	input  grid_pkg::pixel_offset_t offset,
	input  pixel_pkg::colour_t      colour_next,
	output pixel_pkg::x_coord_t     x,
	output pixel_pkg::y_coord_t     y,
	output pixel_pkg::colour_t      colour,
	output logic                    plot
);

	pixel_pkg::x_coord_t x_base; // top left corner of the square
	pixel_pkg::y_coord_t y_base;
	pixel_pkg::x_coord_t x_next;
	pixel_pkg::y_coord_t y_next;

	assign x_base = pixel_pkg::x_coord_t'(`GRID_X0 + `GRID_PITCH * square.pos.step);
	assign y_base = pixel_pkg::y_coord_t'(`GRID_Y0 + `GRID_PITCH * square.pos.instrument);

	// low offset bits walk across, high bits walk down
	assign x_next = x_base + pixel_pkg::x_coord_t'(offset % `SQUARE_SIDE);
	assign y_next = y_base + pixel_pkg::y_coord_t'(offset / `SQUARE_SIDE);

	// pixel payload
	always_ff @(posedge clk) begin
		x <= x_next;
		y <= y_next;
		colour <= colour_next;
	end

	// write strobe, one cycle behind play
	always_ff @(posedge clk) begin
		if (!reset) begin
			plot <= 1'b0;
		end else begin
			plot <= play;
		end
	end

endmodule

// ==== verilog/step_grid_draw.sv ====
`timescale 1ns/1ps

module step_grid_draw (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    play,
	input  grid_pkg::step_pattern_t ins1,
	input  grid_pkg::step_pattern_t ins2,
	input  grid_pkg::step_pattern_t ins3,
	input  grid_pkg::step_pattern_t ins4,
	input  grid_pkg::step_timing_t  timing,
	output pixel_pkg::x_coord_t     x,
	output pixel_pkg::y_coord_t     y,
	output pixel_pkg::colour_t      colour,
	output logic                    plot
);

	grid_pkg::square_index_u square;      // square being drawn
	grid_pkg::pixel_offset_t offset;      // pixel inside it
	pixel_pkg::colour_t      colour_next; // colour before the output register

	square_scanner scanner (
		.clk    (clk),
		.reset  (reset),
		.play   (play),
		.square (square),
		.offset (offset)
	);

	cell_shader shader (
		.square      (square),
		.ins1        (ins1),
		.ins2        (ins2),
		.ins3        (ins3),
		.ins4        (ins4),
		.timing      (timing),
		.colour_next (colour_next)
	);

	pixel_emitter emitter (
		.clk         (clk),
		.reset       (reset),
		.play        (play),
		.square      (square),
		.offset      (offset),
		.colour_next (colour_next),
		.x           (x),
		.y           (y),
		.colour      (colour),
		.plot        (plot)
	);

endmodule

// ==== sim/grid_checker.sv ====
`timescale 1ns/1ps
`include "grid_consts.svh"

module grid_checker (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    play,
	input  grid_pkg::step_pattern_t ins1,
	input  grid_pkg::step_pattern_t ins2,
	input  grid_pkg::step_pattern_t ins3,
	input  grid_pkg::step_pattern_t ins4,
	input  grid_pkg::step_timing_t  timing,
	input  pixel_pkg::x_coord_t     x,
	input  pixel_pkg::y_coord_t     y,
	input  pixel_pkg::colour_t      colour,
	input  logic                    plot,
	output int                      error_count,
	output int                      pixel_count
);

	logic [2:0] model_step;  // column being drawn
	logic [1:0] model_row;   // row being drawn
	logic [3:0] model_pix;   // pixels already drawn in this square
	logic [3:0] model_off;
	logic [7:0] row_pattern;

	logic       started = 1'b0; // at least one clock edge seen
	logic       exp_valid = 1'b0;
	logic       exp_plot = 1'b0;
	logic [7:0] exp_x;
	logic [6:0] exp_y;
	logic [2:0] exp_colour;
	int         errors = 0;
	int         pixels = 0;

	assign error_count = errors;
	assign pixel_count = pixels;
	assign model_off = 4'd15 - model_pix; // pixels are walked from the last one down

	always_comb begin
		case (model_row)
			2'd0: row_pattern = ins1;
			2'd1: row_pattern = ins2;
			2'd2: row_pattern = ins3;
			default: row_pattern = ins4;
		endcase
	end

	function automatic logic [2:0] expected_colour(input logic [7:0] pattern,
		input logic [2:0] step, input logic [3:0] now);
		logic note;
		logic lit;
		note = pattern[step];
		lit = (now >= 4'd1) && (now <= 4'd8) && (3'(now - 4'd1) == step);
		if (note && lit)
			return `COLOUR_HIT;
		if (note)
			return `COLOUR_NOTE;
		if (lit)
			return `COLOUR_CURSOR;
		return `COLOUR_EMPTY;
	endfunction

	task automatic compare_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	// predict what the DUT registers on this edge
	always @(posedge clk) begin
		started <= 1'b1;
		if (!reset) begin
			model_step <= 3'd0;
			model_row <= 2'd0;
			model_pix <= 4'd0;
			exp_valid <= 1'b0;
			exp_plot <= 1'b0;
		end else begin
			exp_valid <= 1'b1;
			exp_plot <= play;
			exp_x <= 8'(`GRID_X0 + `GRID_PITCH * int'(model_step) + int'(model_off[1:0]));
			exp_y <= 7'(`GRID_Y0 + `GRID_PITCH * int'(model_row) + int'(model_off[3:2]));
			exp_colour <= expected_colour(row_pattern, model_step, timing);
			if (play) begin
				if (model_pix == 4'd15) begin
					model_pix <= 4'd0;
					if (model_row == 2'd3) begin
						model_row <= 2'd0;
						model_step <= model_step + 3'd1; // 7 wraps to 0, frame done
					end else begin
						model_row <= model_row + 2'd1;
					end
				end else begin
					model_pix <= model_pix + 4'd1;
				end
			end
		end
	end

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (started) begin
			compare_value("plot", int'(exp_plot), int'(plot));
			if (exp_valid) begin
				compare_value("x", int'(exp_x), int'(x));
				compare_value("y", int'(exp_y), int'(y));
				compare_value("colour", int'(exp_colour), int'(colour));
				if (exp_plot)
					pixels++;
			end
		end
	end

endmodule

// ==== sim/step_grid_draw_props.sv ====
`timescale 1ns/1ps
`include "grid_consts.svh"

module step_grid_draw_props (
	input logic       clk,
	input logic       reset,
	input logic       play,
	input logic [7:0] x,
	input logic [6:0] y,
	input logic [2:0] colour,
	input logic       plot
);

	plot_low_in_reset: assert property (@(posedge clk) !reset |=> !plot)
		else $error("plot high after a reset cycle");

	plot_follows_play: assert property (@(posedge clk) reset |=> (plot == $past(play)))
		else $error("plot does not follow play of the previous cycle");

	colour_is_code: assert property (@(posedge clk) plot |-> (colour == `COLOUR_HIT
		|| colour == `COLOUR_NOTE || colour == `COLOUR_CURSOR || colour == `COLOUR_EMPTY))
		else $error("plotted colour is not one of the four codes");

	address_on_grid: assert property (@(posedge clk) plot |-> (x >= 8'd10 && x <= 8'd153
		&& y >= 7'd20 && y <= 7'd83))
		else $error("plotted address lies outside the grid");

endmodule

// ==== sim/step_grid_draw_tb.sv ====
`timescale 1ns/1ps

module step_grid_draw_tb;

	localparam int num_rows = 10;
	localparam int reset_cycles = 4;
	localparam int margin_cycles = 50;

	typedef struct packed {
		logic [7:0]  ins1;
		logic [7:0]  ins2;
		logic [7:0]  ins3;
		logic [7:0]  ins4;
		logic [3:0]  timing;
		logic        play;
		logic [15:0] cycles; // clocks this row is held
	} stim_row_t;

	logic                    clk;
	logic                    reset;
	logic                    play;
	grid_pkg::step_pattern_t ins1;
	grid_pkg::step_pattern_t ins2;
	grid_pkg::step_pattern_t ins3;
	grid_pkg::step_pattern_t ins4;
	grid_pkg::step_timing_t  timing;
	pixel_pkg::x_coord_t     x;
	pixel_pkg::y_coord_t     y;
	pixel_pkg::colour_t      colour;
	logic                    plot;
	int                      error_count;
	int                      pixel_count;

	stim_row_t rows [num_rows];
	string     row_names [num_rows];
	int        total_cycles;

	step_grid_draw UUT (
		.clk(clk), .reset(reset), .play(play),
		.ins1(ins1), .ins2(ins2), .ins3(ins3), .ins4(ins4), .timing(timing),
		.x(x), .y(y), .colour(colour), .plot(plot)
	);

	grid_checker grid_check (
		.clk(clk), .reset(reset), .play(play),
		.ins1(ins1), .ins2(ins2), .ins3(ins3), .ins4(ins4), .timing(timing),
		.x(x), .y(y), .colour(colour), .plot(plot),
		.error_count(error_count), .pixel_count(pixel_count)
	);

	bind step_grid_draw step_grid_draw_props props (
		.clk(clk), .reset(reset), .play(play),
		.x(x), .y(y), .colour(colour), .plot(plot)
	);

	function automatic stim_row_t make_row(input logic [7:0] p1, input logic [7:0] p2,
		input logic [7:0] p3, input logic [7:0] p4, input logic [3:0] now,
		input logic run, input logic [15:0] count);
		return '{ins1: p1, ins2: p2, ins3: p3, ins4: p4, timing: now, play: run, cycles: count};
	endfunction

	task automatic fill_table();
		rows[0] = make_row(8'h81, 8'h44, 8'h2a, 8'h10, 4'd3, 1'b1, 16'd512); // one whole frame
		row_names[0] = "first frame";
		rows[1] = make_row(8'h81, 8'h44, 8'h2a, 8'h10, 4'd3, 1'b0, 16'd7);
		row_names[1] = "pause";
		rows[2] = make_row(8'hff, 8'h00, 8'h55, 8'haa, 4'd0, 1'b1, 16'd100); // no column lit
		row_names[2] = "resume, timing 0";
		rows[3] = make_row(8'hff, 8'h00, 8'h55, 8'haa, 4'd0, 1'b0, 16'd3);
		row_names[3] = "pause mid square";
		rows[4] = make_row(8'h0f, 8'hf0, 8'hff, 8'h00, 4'd8, 1'b1, 16'd430); // crosses the wrap
		row_names[4] = "wrap, timing 8";
		for (int i = 5; i < num_rows; i++) begin
			rows[i] = make_row(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom),
				4'($urandom % 9), ($urandom % 4) != 0, 16'(24 + $urandom % 64));
			row_names[i] = $sformatf("random %0d", i - 4);
		end
	endtask

	// called on a falling edge, holds the row for its cycle count
	task automatic apply_row(input int idx);
		ins1 = rows[idx].ins1;
		ins2 = rows[idx].ins2;
		ins3 = rows[idx].ins3;
		ins4 = rows[idx].ins4;
		timing = rows[idx].timing;
		play = rows[idx].play;
		repeat (int'(rows[idx].cycles)) @(negedge clk);
		$display("row %0d %s: %0d cycles, play %0b, timing %0d, errors so far %0d",
			idx, row_names[idx], rows[idx].cycles, rows[idx].play, rows[idx].timing,
			error_count);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int limit_cycles;
		reset = 1'b0;
		play = 1'b0;
		ins1 = '0;
		ins2 = '0;
		ins3 = '0;
		ins4 = '0;
		timing = '0;
		void'($urandom(32'h9198));
		fill_table();
		total_cycles = reset_cycles;
		foreach (rows[i])
			total_cycles += int'(rows[i].cycles);
		limit_cycles = total_cycles + margin_cycles;
		fork
			begin
				#(limit_cycles * 20);
				$display("timeout: stimulus did not finish within %0d cycles", limit_cycles);
				$display("*** TEST FAILED ***");
				$finish;
			end
		join_none
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk); // falling edge after the last reset clock
		reset = 1'b1;
		for (int i = 0; i < num_rows; i++)
			apply_row(i);
		play = 1'b0;
		repeat (2) @(posedge clk); // let the last pixel be compared
		$display("done: %0d rows, %0d pixels checked, %0d errors",
			num_rows, pixel_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/grid_pkg.sv
verilog/pixel_pkg.sv
verilog/square_scanner.sv
verilog/cell_shader.sv
verilog/pixel_emitter.sv
verilog/step_grid_draw.sv
sim/grid_checker.sv
sim/step_grid_draw_props.sv
sim/step_grid_draw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the step grid testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f \
	--top-module step_grid_draw_tb -o step_grid_draw_sim

./obj_dir/step_grid_draw_sim 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
